/* dec.f */
rtl/dec_pkg.sv
rtl/dec_wb_if.sv
rtl/dec_ib_ctl.sv
rtl/dec_pipe_ctl.sv
rtl/dec_gpr_ctl.sv
rtl/dec_halt_ctl.sv
rtl/dec_perf_ctr.sv
rtl/dec.sv
test/tb_dec.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_dec
FILELIST := dec.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* test/tb_dec.sv */
// decode unit testbench
`timescale 1ns/1ns
`default_nettype none

module tb_dec
   import dec_pkg::*;
();

   localparam int IB_DEPTH  = ib_depth_def;
   localparam int CNT_W     = cnt_w_def;
   localparam int NUM_TESTS = 6;

   logic             clk;
   logic             rst_n;
   logic             ifu_i0_valid;
   logic [xlen-1:0]  ifu_i0_instr;
   logic [xlen-1:1]  ifu_i0_pc;
   logic             i_cpu_halt_req;
   logic             i_cpu_run_req;
   logic             dec_ib_full;
   logic             o_cpu_halt_ack;
   logic             o_cpu_run_ack;
   logic             o_cpu_halt_status;
   logic             trace_valid;
   logic             trace_exception;
   logic [xlen-1:0]  trace_insn;
   logic [xlen-1:1]  trace_address;
   logic [xlen-1:0]  dec_dbg_rddata;
   logic [CNT_W-1:0] dec_instret_count;
   logic [CNT_W-1:0] dec_illegal_count;

   integer           seed = 32'he2288da5;
   int               errors = 0;
   int               n_sent = 0;         // strobes sent
   int               n_pass = 0;
   int               n_fail = 0;
   int               test_num = 0;
   int               wd_cycles = 0;
   logic [xlen-1:1]  pc_next = '0;

   // reference model
   logic [xlen-1:0]  insn_q [$];         // accepted insns in program order
   logic [xlen-1:1]  pc_q [$];
   logic [xlen-1:0]  mregs [32];
   int               legal_cnt = 0;
   int               illegal_cnt = 0;
   bit               exp_have = 1'b0;    // an insn is outstanding
   bit               exp_legal;
   logic [xlen-1:0]  exp_insn;
   logic [xlen-1:0]  exp_data;
   logic [xlen-1:1]  exp_pc;

   dec uut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;              // 4 ns period
   end

   // **************************************************
   // encoders and model
   // **************************************************
   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd);
      return {imm, rs1, 3'b000, rd, 7'h13};   // addi
   endfunction

   function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'h37};
   endfunction

   // returns the legal flag with the result in res
   function automatic bit model_exec(input logic [31:0] ins, output logic [31:0] res);
      logic [31:0] a;
      logic [31:0] b;
      a   = mregs[ins[19:15]];
      b   = mregs[ins[24:20]];
      res = '0;
      if (ins[6:0] == 7'h33) begin
         case ({ins[31:25], ins[14:12]})
            10'h000: res = a + b;
            10'h100: res = a - b;          // sub
            10'h004: res = a ^ b;
            10'h006: res = a | b;
            10'h007: res = a & b;
            default: return 1'b0;
         endcase
         return 1'b1;
      end
      if (ins[6:0] == 7'h13 && ins[14:12] == 3'b000) begin
         res = a + {{20{ins[31]}}, ins[31:20]};
         return 1'b1;
      end
      if (ins[6:0] == 7'h37) begin
         res = {ins[31:12], 12'h000};
         return 1'b1;
      end
      return 1'b0;
   endfunction

   // seven legal ops over x0..x7 give frequent dependences
   function automatic logic [31:0] rand_insn();
      logic [31:0] r;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      r   = $random(seed);
      rd  = {2'b00, r[10:8]};
      rs1 = {2'b00, r[13:11]};
      rs2 = {2'b00, r[16:14]};
      case (r[2:0])
         3'd1:    return enc_r(7'h20, 3'b000, rd, rs1, rs2);   // sub
         3'd2:    return enc_r(7'h00, 3'b111, rd, rs1, rs2);   // and
         3'd3:    return enc_r(7'h00, 3'b110, rd, rs1, rs2);   // or
         3'd4:    return enc_r(7'h00, 3'b100, rd, rs1, rs2);   // xor
         3'd5:    return enc_i(r[31:20], rs1, rd);
         3'd6:    return enc_lui(r[31:12], rd);
         default: return enc_r(7'h00, 3'b000, rd, rs1, rs2);   // add
      endcase
   endfunction

   // retire on trace_valid then expect the new head
   always @(posedge clk) begin
      logic [31:0] res;
      bit          legal;
      if (rst_n && trace_valid && insn_q.size() != 0) begin
         legal = model_exec(insn_q[0], res);
         if (legal) begin
            legal_cnt++;
            if (insn_q[0][11:7] != 5'd0) begin
               mregs[insn_q[0][11:7]] = res;   // x0 stays zero
            end
         end else begin
            illegal_cnt++;
         end
         void'(insn_q.pop_front());
         void'(pc_q.pop_front());
      end
      exp_have = (insn_q.size() != 0);
      if (exp_have) begin
         exp_legal = model_exec(insn_q[0], exp_data);
         exp_insn  = insn_q[0];
         exp_pc    = pc_q[0];
      end
   end

   // **************************************************
   // checks sampled mid-cycle
   // **************************************************
   a_known: assert property (@(negedge clk) disable iff (!rst_n) trace_valid |-> exp_have)
      else begin
         $display("trace_valid with no instruction outstanding");
         errors++;
      end
   a_insn: assert property (@(negedge clk) disable iff (!rst_n)
                            trace_valid && exp_have |-> trace_insn == exp_insn)
      else begin
         $display("mismatch trace_insn got %h expected %h", trace_insn, exp_insn);
         errors++;
      end
   a_addr: assert property (@(negedge clk) disable iff (!rst_n)
                            trace_valid && exp_have |-> trace_address == exp_pc)
      else begin
         $display("mismatch trace_address got %h expected %h", trace_address, exp_pc);
         errors++;
      end
   a_exc: assert property (@(negedge clk) disable iff (!rst_n)
                           trace_valid && exp_have |-> trace_exception == !exp_legal)
      else begin
         $display("mismatch trace_exception got %h expected %h", trace_exception, !exp_legal);
         errors++;
      end
   a_data: assert property (@(negedge clk) disable iff (!rst_n)
                            trace_valid && exp_have && exp_legal |-> dec_dbg_rddata == exp_data)
      else begin
         $display("mismatch dec_dbg_rddata got %h expected %h", dec_dbg_rddata, exp_data);
         errors++;
      end
   a_halted: assert property (@(negedge clk) disable iff (!rst_n)
                              o_cpu_halt_status |-> !trace_valid)
      else begin
         $display("instruction retired while halted");
         errors++;
      end
   a_halt_ack: assert property (@(negedge clk) disable iff (!rst_n)
                                o_cpu_halt_ack |-> o_cpu_halt_status && !$past(o_cpu_halt_ack))
      else begin
         $display("halt ack is not a single pulse with halt status");
         errors++;
      end
   a_run_ack: assert property (@(negedge clk) disable iff (!rst_n)
                               o_cpu_run_ack |-> !o_cpu_halt_status && !$past(o_cpu_run_ack))
      else begin
         $display("run ack is not a single pulse out of halt");
         errors++;
      end

   // **************************************************
   // stimulus tasks
   // **************************************************
   task automatic tick();
      @(posedge clk);
      ifu_i0_valid   <= 1'b0;             // strobes last one cycle
      i_cpu_halt_req <= 1'b0;
      i_cpu_run_req  <= 1'b0;
   endtask

   task automatic send_insn(input logic [31:0] instr, input bit dropped);
      tick();
      ifu_i0_valid <= 1'b1;
      ifu_i0_instr <= instr;
      ifu_i0_pc    <= pc_next;
      if (!dropped) begin
         insn_q.push_back(instr);
         pc_q.push_back(pc_next);
      end
      pc_next = pc_next + 31'd2;          // 4 bytes in halfword units
      n_sent++;
   endtask

   task automatic request_halt_and_wait();
      tick();
      i_cpu_halt_req <= 1'b1;
      tick();
      @(negedge clk);
      while (!o_cpu_halt_ack) begin
         tick();
         @(negedge clk);
      end
   endtask

   task automatic request_run_and_wait();
      tick();
      i_cpu_run_req <= 1'b1;
      tick();
      @(negedge clk);
      while (!o_cpu_run_ack) begin
         tick();
         @(negedge clk);
      end
   endtask

   task automatic end_test(input string name, input int err_start);
      tick();
      @(negedge clk);
      while (insn_q.size() != 0) begin    // wait for the last retire
         tick();
         @(negedge clk);
      end
      test_num++;
      if (errors == err_start) begin
         n_pass++;
         $display("test %0d %s: ok", test_num, name);
      end else begin
         n_fail++;
         $display("test %0d %s: failed with %0d errors", test_num, name, errors - err_start);
      end
   endtask

   // **************************************************
   // test sequence
   // **************************************************
   initial begin
      int          err_start;
      logic [31:0] gap;
      rst_n          = 1'b0;
      ifu_i0_valid   = 1'b0;
      ifu_i0_instr   = '0;
      ifu_i0_pc      = '0;
      i_cpu_halt_req = 1'b0;
      i_cpu_run_req  = 1'b0;
      for (int i = 0; i < 32; i++) begin
         mregs[i] = '0;
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      tick();

      err_start = errors;                 // random dependent stream
      for (int i = 0; i < 48; i++) begin
         send_insn(rand_insn(), 1'b0);
         gap = $random(seed);
         if (gap[1:0] == 2'b00) begin
            tick();
         end
      end
      end_test("random stream", err_start);

      err_start = errors;
      send_insn(enc_i(12'h055, 5'd0, 5'd0), 1'b0);            // addi x0
      send_insn(enc_r(7'h00, 3'b000, 5'd1, 5'd0, 5'd0), 1'b0);
      send_insn(enc_lui(20'habcde, 5'd0), 1'b0);
      send_insn(enc_i(12'h007, 5'd0, 5'd2), 1'b0);
      send_insn(enc_r(7'h00, 3'b110, 5'd3, 5'd0, 5'd2), 1'b0);
      end_test("x0 writes", err_start);

      err_start = errors;
      send_insn(enc_i(12'h123, 5'd0, 5'd5), 1'b0);
      send_insn({20'h12345, 5'd5, 7'h7f}, 1'b0);               // unknown opcode
      send_insn(enc_r(7'h01, 3'b000, 5'd5, 5'd1, 5'd2), 1'b0); // bad funct7
      send_insn({12'h001, 5'd0, 3'b010, 5'd5, 7'h13}, 1'b0);   // bad funct3
      send_insn(enc_r(7'h00, 3'b000, 5'd6, 5'd5, 5'd0), 1'b0);
      end_test("illegal instructions", err_start);

      err_start = errors;
      for (int i = 0; i < 4; i++) begin
         send_insn(rand_insn(), 1'b0);
      end
      request_halt_and_wait();
      for (int i = 0; i < 5; i++) begin
         tick();
         @(negedge clk);
         assert (o_cpu_halt_status)
            else begin
               $display("halt status dropped while halted");
               errors++;
            end
      end
      for (int i = 0; i < 3; i++) begin
         send_insn(rand_insn(), 1'b0);
      end
      repeat (10) tick();                 // nothing may retire here
      request_run_and_wait();
      end_test("halt and run", err_start);

      err_start = errors;
      request_halt_and_wait();
      for (int i = 0; i < IB_DEPTH; i++) begin
         send_insn(rand_insn(), 1'b0);
      end
      tick();
      @(negedge clk);
      assert (dec_ib_full)
         else begin
            $display("buffer not full after %0d strobes", IB_DEPTH);
            errors++;
         end
      send_insn(rand_insn(), 1'b1);       // lost and never traced
      tick();
      @(negedge clk);
      assert (dec_ib_full)
         else begin
            $display("buffer full flag dropped while halted");
            errors++;
         end
      request_run_and_wait();
      end_test("buffer full", err_start);

      err_start = errors;
      tick();
      @(negedge clk);
      assert (dec_instret_count == CNT_W'(legal_cnt))
         else begin
            $display("mismatch dec_instret_count got %h expected %h",
                     dec_instret_count, CNT_W'(legal_cnt));
            errors++;
         end
      assert (dec_illegal_count == CNT_W'(illegal_cnt))
         else begin
            $display("mismatch dec_illegal_count got %h expected %h",
                     dec_illegal_count, CNT_W'(illegal_cnt));
            errors++;
         end
      end_test("counters", err_start);

      $display("tests passed %0d failed %0d, %0d errors", n_pass, n_fail, errors);
      if (errors == 0 && n_fail == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // watchdog limit grows with the strobes sent
   initial begin
      while (wd_cycles < 200 * NUM_TESTS + 20 * n_sent) begin
         @(posedge clk);
         wd_cycles++;
      end
      $display("timeout after %0d cycles", wd_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/dec.sv */
// decode unit top
`timescale 1ns/1ns
`default_nettype none

module dec
   import dec_pkg::*;
#(
   parameter int IB_DEPTH = ib_depth_def,
   parameter int CNT_W    = cnt_w_def
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             ifu_i0_valid,        // fetch strobe
   input  logic [xlen-1:0]  ifu_i0_instr,
   input  logic [xlen-1:1]  ifu_i0_pc,
   input  logic             i_cpu_halt_req,
   input  logic             i_cpu_run_req,
   output logic             dec_ib_full,
   output logic             o_cpu_halt_ack,
   output logic             o_cpu_run_ack,
   output logic             o_cpu_halt_status,
   output logic             trace_valid,
   output logic             trace_exception,
   output logic [xlen-1:0]  trace_insn,
   output logic [xlen-1:1]  trace_address,
   output logic [xlen-1:0]  dec_dbg_rddata,      // writeback data
   output logic [CNT_W-1:0] dec_instret_count,
   output logic [CNT_W-1:0] dec_illegal_count
);

   logic                  ib_valid;
   logic [xlen-1:0]       ib_instr;
   logic [xlen-1:1]       ib_pc;
   logic                  ib_take;
   logic                  dec_run;
   logic                  pipe_idle;
   logic [reg_addr_w-1:0] gpr_raddr0;
   logic [reg_addr_w-1:0] gpr_raddr1;
   logic [xlen-1:0]       gpr_rd0;
   logic [xlen-1:0]       gpr_rd1;

   dec_wb_if wb ();

   dec_ib_ctl #(.IB_DEPTH(IB_DEPTH)) instbuff (.*);

   dec_pipe_ctl pipe (.*);

   dec_gpr_ctl arf (.*);

   dec_halt_ctl halt (.*);

   dec_perf_ctr #(.CNT_W(CNT_W)) perf (.*);

   // ************************************************
   // trace and debug taps on writeback
   // ************************************************
   assign trace_valid     = wb.wb_valid;
   assign trace_exception = wb.wb_illegal;     // illegal insn only
   assign trace_insn      = wb.wb_instr;
   assign trace_address   = wb.wb_pc;
   assign dec_dbg_rddata  = wb.wb_wdata;

endmodule

`default_nettype wire

/* rtl/dec_perf_ctr.sv */
// retire counters
`timescale 1ns/1ns
`default_nettype none

module dec_perf_ctr
   import dec_pkg::*;
#(
   parameter int CNT_W = cnt_w_def
) (
   input  logic             clk,
   input  logic             rst_n,
   dec_wb_if.sink           wb,
   output logic [CNT_W-1:0] dec_instret_count,   // legal retirements
   output logic [CNT_W-1:0] dec_illegal_count    // illegal retirements
);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dec_instret_count <= '0;
         dec_illegal_count <= '0;
      end else if (wb.wb_valid) begin
         if (wb.wb_illegal) begin
            dec_illegal_count <= dec_illegal_count + 1'b1;   // wraps
         end else begin
            dec_instret_count <= dec_instret_count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/dec_halt_ctl.sv */
// halt and run control
`timescale 1ns/1ns
`default_nettype none

module dec_halt_ctl
   import dec_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic i_cpu_halt_req,     // one-cycle strobe
   input  logic i_cpu_run_req,      // one-cycle strobe
   input  logic pipe_idle,
   output logic dec_run,
   output logic o_cpu_halt_ack,
   output logic o_cpu_run_ack,
   output logic o_cpu_halt_status
);

   halt_state_e state;

   assign dec_run           = (state == st_run);      // drain blocks takes
   assign o_cpu_halt_status = (state == st_halted);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state          <= st_run;
         o_cpu_halt_ack <= 1'b0;
         o_cpu_run_ack  <= 1'b0;
      end else begin
         o_cpu_halt_ack <= 1'b0;             // acks are single pulses
         o_cpu_run_ack  <= 1'b0;
         case (state)
            st_run: begin
               if (i_cpu_halt_req) begin
                  state <= st_drain;
               end
            end
            st_drain: begin
               if (pipe_idle) begin
                  state          <= st_halted;
                  o_cpu_halt_ack <= 1'b1;
               end
            end
            st_halted: begin
               if (i_cpu_run_req) begin
                  state         <= st_run;
                  o_cpu_run_ack <= 1'b1;
               end
            end
            default: state <= st_run;        // unused encoding
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/dec_gpr_ctl.sv */
// integer register file
`timescale 1ns/1ns
`default_nettype none

module dec_gpr_ctl
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [reg_addr_w-1:0] gpr_raddr0,
   input  logic [reg_addr_w-1:0] gpr_raddr1,
   dec_wb_if.sink                wb,
   output logic [xlen-1:0]       gpr_rd0,
   output logic [xlen-1:0]       gpr_rd1
);

   logic [xlen-1:0] regs [32];              // x0 held at zero by the pipe

   // async read ports
   assign gpr_rd0 = regs[gpr_raddr0];
   assign gpr_rd1 = regs[gpr_raddr1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.wb_wen) begin
         regs[wb.wb_waddr] <= wb.wb_wdata;   // single write port
      end
   end

endmodule

`default_nettype wire

/* rtl/dec_pipe_ctl.sv */
// decode, execute and writeback pipe
`timescale 1ns/1ns
`default_nettype none

module dec_pipe_ctl
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  ib_valid,
   input  logic [xlen-1:0]       ib_instr,
   input  logic [xlen-1:1]       ib_pc,
   input  logic                  dec_run,       // halt control allows takes
   input  logic [xlen-1:0]       gpr_rd0,       // rs1 from arf
   input  logic [xlen-1:0]       gpr_rd1,       // rs2 from arf
   output logic                  ib_take,
   output logic                  pipe_idle,
   output logic [reg_addr_w-1:0] gpr_raddr0,
   output logic [reg_addr_w-1:0] gpr_raddr1,
   dec_wb_if.src                 wb
);

   localparam logic [2:0] f3_add = 3'b000;   // also sub, addi
   localparam logic [2:0] f3_xor = 3'b100;
   localparam logic [2:0] f3_or  = 3'b110;
   localparam logic [2:0] f3_and = 3'b111;
   localparam logic [6:0] f7_std = 7'b0000000;
   localparam logic [6:0] f7_alt = 7'b0100000;   // sub

   op_e                   dec_op;
   logic                  dec_use_imm;
   logic [xlen-1:0]       dec_imm;
   logic [reg_addr_w-1:0] dec_rd;
   logic                  dec_wen;
   logic [xlen-1:0]       dec_a;
   logic [xlen-1:0]       dec_rs2;

   logic                  ex_valid;
   op_e                   ex_op;
   logic [xlen-1:0]       ex_a;
   logic [xlen-1:0]       ex_b;
   logic [reg_addr_w-1:0] ex_rd;
   logic                  ex_wen;
   logic [xlen-1:1]       ex_pc;
   logic [xlen-1:0]       ex_instr;
   logic [xlen-1:0]       ex_result;

   // ************************************************
   // decode
   // ************************************************
   assign ib_take    = ib_valid & dec_run;
   assign gpr_raddr0 = ib_instr[19:15];      // rs1
   assign gpr_raddr1 = ib_instr[24:20];      // rs2
   assign dec_rd     = ib_instr[11:7];

   always_comb begin
      dec_op      = op_illegal;              // unknown until matched
      dec_use_imm = 1'b0;
      case (ib_instr[6:0])
         opc_op: begin
            if (ib_instr[31:25] == f7_std) begin
               case (ib_instr[14:12])
                  f3_add:  dec_op = op_add;
                  f3_xor:  dec_op = op_xor;
                  f3_or:   dec_op = op_or;
                  f3_and:  dec_op = op_and;
                  default: dec_op = op_illegal;
               endcase
            end else if (ib_instr[31:25] == f7_alt && ib_instr[14:12] == f3_add) begin
               dec_op = op_sub;
            end
         end
         opc_op_imm: begin
            if (ib_instr[14:12] == f3_add) begin
               dec_op      = op_addi;
               dec_use_imm = 1'b1;
            end
         end
         opc_lui: begin
            dec_op      = op_lui;
            dec_use_imm = 1'b1;
         end
         default: dec_op = op_illegal;
      endcase
   end

   assign dec_imm = (ib_instr[6:0] == opc_lui) ? {ib_instr[31:12], 12'b0}
                                               : {{(xlen-12){ib_instr[31]}}, ib_instr[31:20]};
   assign dec_wen = (dec_op != op_illegal) & (dec_rd != '0);   // x0 never written

   // newest producer wins over writeback data and arf
   function automatic logic [xlen-1:0] fwd(input logic [reg_addr_w-1:0] idx,
                                           input logic [xlen-1:0]       rf_val);
      if (ex_valid && ex_wen && ex_rd == idx) begin
         return ex_result;
      end else if (wb.wb_wen && wb.wb_waddr == idx) begin
         return wb.wb_wdata;                 // not yet in arf
      end
      return rf_val;
   endfunction

   always_comb begin
      dec_a   = fwd(gpr_raddr0, gpr_rd0);
      dec_rs2 = fwd(gpr_raddr1, gpr_rd1);
   end

   // ************************************************
   // execute
   // ************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
         ex_wen   <= 1'b0;
      end else begin
         ex_valid <= ib_take;
         ex_wen   <= ib_take & dec_wen;
      end
   end

   always_ff @(posedge clk) begin
      if (ib_take) begin
         ex_op    <= dec_op;
         ex_a     <= dec_a;
         ex_b     <= dec_use_imm ? dec_imm : dec_rs2;   // imm replaces rs2
         ex_rd    <= dec_rd;
         ex_pc    <= ib_pc;
         ex_instr <= ib_instr;
      end
   end

   always_comb begin
      case (ex_op)
         op_add, op_addi: ex_result = ex_a + ex_b;
         op_sub:          ex_result = ex_a - ex_b;
         op_and:          ex_result = ex_a & ex_b;
         op_or:           ex_result = ex_a | ex_b;
         op_xor:          ex_result = ex_a ^ ex_b;
         op_lui:          ex_result = ex_b;
         default:         ex_result = '0;     // illegal insn gives zero
      endcase
   end

   // ************************************************
   // writeback
   // ************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb.wb_valid   <= 1'b0;
         wb.wb_illegal <= 1'b0;
         wb.wb_wen     <= 1'b0;
      end else begin
         wb.wb_valid   <= ex_valid;
         wb.wb_illegal <= ex_valid & (ex_op == op_illegal);
         wb.wb_wen     <= ex_valid & ex_wen;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_valid) begin
         wb.wb_waddr <= ex_rd;
         wb.wb_wdata <= ex_result;
         wb.wb_pc    <= ex_pc;
         wb.wb_instr <= ex_instr;
      end
   end

   assign pipe_idle = ~ex_valid & ~wb.wb_valid;   // nothing past the buffer

endmodule

`default_nettype wire

/* rtl/dec_ib_ctl.sv */
// instruction buffer
`timescale 1ns/1ns
`default_nettype none

module dec_ib_ctl
   import dec_pkg::*;
#(
   parameter int IB_DEPTH = ib_depth_def
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            ifu_i0_valid,    // fetch strobe
   input  logic [xlen-1:0] ifu_i0_instr,
   input  logic [xlen-1:1] ifu_i0_pc,
   input  logic            ib_take,         // decode accepts head
   output logic            ib_valid,        // head entry present
   output logic [xlen-1:0] ib_instr,
   output logic [xlen-1:1] ib_pc,
   output logic            dec_ib_full
);

   localparam int PTR_W = (IB_DEPTH > 1) ? $clog2(IB_DEPTH) : 1;
   localparam int CNT_W = $clog2(IB_DEPTH + 1);

   logic [xlen-1:0]  instr_mem [IB_DEPTH];   // payload
   logic [xlen-1:1]  pc_mem    [IB_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;                  // occupancy
   logic             push;
   logic             pop;

   assign dec_ib_full = (count == CNT_W'(IB_DEPTH));
   assign push        = ifu_i0_valid & ~dec_ib_full;   // strobe while full is lost
   assign pop         = ib_take & ib_valid;

   assign ib_valid = (count != '0);
   assign ib_instr = instr_mem[rd_ptr];      // head to decode
   assign ib_pc    = pc_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         instr_mem[wr_ptr] <= ifu_i0_instr;
         pc_mem[wr_ptr]    <= ifu_i0_pc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(IB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // wrap
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(IB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(push) - CNT_W'(pop);   // push and pop may coincide
      end
   end

endmodule

`default_nettype wire

/* rtl/dec_wb_if.sv */
// writeback bundle
`timescale 1ns/1ns
`default_nettype none

interface dec_wb_if
   import dec_pkg::*;
();
   logic                  wb_valid;      // one-cycle retire strobe
   logic                  wb_illegal;    // retiring insn was illegal
   logic                  wb_wen;        // gpr write enable
   logic [reg_addr_w-1:0] wb_waddr;      // gpr write index
   logic [xlen-1:0]       wb_wdata;      // result data
   logic [xlen-1:1]       wb_pc;         // pc of retiring insn
   logic [xlen-1:0]       wb_instr;      // raw insn bits

   modport src  (output wb_valid, wb_illegal, wb_wen, wb_waddr, wb_wdata, wb_pc, wb_instr);
   modport sink (input  wb_valid, wb_illegal, wb_wen, wb_waddr, wb_wdata, wb_pc, wb_instr);

endinterface

`default_nettype wire

/* rtl/dec_pkg.sv */
// decode unit shared definitions
`default_nettype none

package dec_pkg;

   // ************************************************
   // widths and defaults
   // ************************************************
   localparam int xlen         = 32;          // data path width
   localparam int reg_addr_w   = 5;           // gpr index width
   localparam int ib_depth_def = 4;           // instruction buffer entries
   localparam int cnt_w_def    = 32;          // perf counter width

   // major opcodes accepted by decode
   localparam logic [6:0] opc_op     = 7'b0110011;   // reg-reg alu
   localparam logic [6:0] opc_op_imm = 7'b0010011;   // reg-imm alu
   localparam logic [6:0] opc_lui    = 7'b0110111;   // load upper imm

   // decoded operation
   typedef enum logic [2:0] {
      op_add     = 3'd0,
      op_sub     = 3'd1,
      op_and     = 3'd2,
      op_or      = 3'd3,
      op_xor     = 3'd4,
      op_addi    = 3'd5,
      op_lui     = 3'd6,
      op_illegal = 3'd7                       // retires as exception without write
   } op_e;

   // halt control states
   typedef enum logic [1:0] {
      st_run    = 2'd0,
      st_drain  = 2'd1,                       // waiting for pipe to empty
      st_halted = 2'd2
   } halt_state_e;

endpackage

`default_nettype wire
